// ==== Makefile ====
# Verilator flow for the virtual UDP port receive path

VERILATOR ?= verilator
TOP       ?= virtual_port_rx_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_ARGS  ?=

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o $(TOP)

# Exit status of the simulation is the result
sim: build
	./$(BUILD_DIR)/$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)

// ==== all.f ====
+incdir+common
common/udp_rx_pkg.sv
common/udp_rx_if.sv
hdl/internet_checksum.sv
hdl/udp_rx_parser.sv
reassembly/fragment_slot.sv
reassembly/fragment_arbiter.sv
hdl/virtual_port_rx.sv
verif/virtual_port_rx_asserts.sv
verif/virtual_port_rx_tb.sv

// ==== common/udp_rx_defines.svh ====
// Sizing constants for the virtual UDP port receive path
`ifndef UDP_RX_DEFINES_SVH
`define UDP_RX_DEFINES_SVH

// Peer reassembly slots sharing the module output
`define FRAGMENT_SLOTS 2

// Payload capacity of one slot in bytes
`define SLOT_BYTES 64

// Identification, flags/fragment word and checksum, two bytes each
`define HEADER_BYTES 6

`endif

// ==== common/udp_rx_if.sv ====
// Parser to slot write port and slot to arbiter drain port
`timescale 1ns/1ps

interface slot_write_if;
    logic                   select;
    logic                   write;
    logic [7:0]             data;
    logic                   commit;
    logic                   last_fragment;
    logic                   discard;
    udp_rx_pkg::packet_id_t packet_id;
    logic                   occupied;
    logic                   sealed;
    udp_rx_pkg::packet_id_t held_id;

    modport parser (
        output select, write, data, commit, last_fragment, discard, packet_id,
        input  occupied, sealed, held_id
    );

    modport slot (
        input  select, write, data, commit, last_fragment, discard, packet_id,
        output occupied, sealed, held_id
    );
endinterface

interface slot_read_if;
    logic                     req;
    logic                     ack;
    udp_rx_pkg::stream_word_t data;
    logic                     valid;
    logic                     ready;

    // Four-phase req/ack around a valid/ready byte stream
    modport slot (output req, data, valid, input ack, ready);

    modport arbiter (input req, data, valid, output ack, ready);
endinterface

// ==== common/udp_rx_pkg.sv ====
// Shared types for the virtual UDP port receive path
package udp_rx_pkg;

    // Stream word, last flag on bit 8
    typedef struct packed {
        logic       last;
        logic [7:0] data;
    } stream_word_t;

    typedef logic [15:0] packet_id_t;

    typedef struct packed {
        logic        reserved;
        logic        dont_fragment;
        logic        more_fragments;
        logic [12:0] offset;
    } flags_fragment_fields_t;

    // Raw view while the two bytes arrive, field view for decode
    typedef union packed {
        logic [15:0]            raw;
        flags_fragment_fields_t fields;
    } flags_fragment_u;

endpackage

// ==== hdl/internet_checksum.sv ====
// Internet checksum check over a byte stream, ok flagged after the last byte
`timescale 1ns/1ps

module internet_checksum (
    input  logic       clock,
    input  logic       rst,
    input  logic [7:0] data,
    input  logic       data_enable,
    input  logic       data_last,
    output logic       ok,
    output logic       done
);

    logic [16:0] acc;         // Bit 16 is the pending end-around carry
    logic [7:0]  high_byte;
    logic        have_high;
    logic [15:0] word;
    logic [16:0] sum_next;
    logic [16:0] folded;

    always_comb begin
        word     = have_high ? {high_byte, data} : {data, 8'h00};  // Odd tail padded low
        sum_next = {1'b0, acc[15:0]} + {1'b0, word} + {16'd0, acc[16]};
        folded   = {1'b0, sum_next[15:0]} + {16'd0, sum_next[16]};
    end

    always_ff @(posedge clock) begin
        if (data_enable && !have_high) begin
            high_byte <= data;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            acc       <= '0;
            have_high <= 1'b0;
            ok        <= 1'b0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            if (data_enable) begin
                if (data_last) begin
                    ok        <= folded == 17'h0ffff;
                    done      <= 1'b1;
                    acc       <= '0;
                    have_high <= 1'b0;
                end else if (have_high) begin
                    acc       <= sum_next;
                    have_high <= 1'b0;
                end else begin
                    have_high <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== hdl/udp_rx_parser.sv ====
// Datagram header decode, fragment slot selection and commit or discard
`timescale 1ns/1ps
`include "udp_rx_defines.svh"

module udp_rx_parser (
    input  logic                     clock,
    input  logic                     rst,
    input  udp_rx_pkg::stream_word_t receive_data,
    input  logic                     receive_data_enable,
    slot_write_if.parser             slots [`FRAGMENT_SLOTS]
);

    localparam int SLOTS = `FRAGMENT_SLOTS;
    localparam int IDX_W = (SLOTS > 1) ? $clog2(SLOTS) : 1;
    localparam int HDR_W = $clog2(`HEADER_BYTES + 1);
    localparam logic [HDR_W-1:0] PAYLOAD = HDR_W'(`HEADER_BYTES);

    logic [HDR_W-1:0]                hdr_count;
    udp_rx_pkg::packet_id_t          packet_id;
    udp_rx_pkg::flags_fragment_u     flags;
    logic                            sel_valid;
    logic [IDX_W-1:0]                sel_index;
    logic                            hit;
    logic [IDX_W-1:0]                hit_index;
    logic [SLOTS-1:0]                occupied_vec;
    logic [SLOTS-1:0]                sealed_vec;
    udp_rx_pkg::packet_id_t          held_id_arr [SLOTS];
    logic                            checksum_ok;
    logic                            checksum_done;

    internet_checksum checksum_inst (
        .clock       (clock),
        .rst         (rst),
        .data        (receive_data.data),
        .data_enable (receive_data_enable),
        .data_last   (receive_data.last),
        .ok          (checksum_ok),
        .done        (checksum_done)
    );

    //////////////////////////////////////////////////////////////////////
    // Header capture
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (receive_data_enable) begin
            case (hdr_count)
                HDR_W'(0): packet_id[15:8] <= receive_data.data;
                HDR_W'(1): packet_id[7:0]  <= receive_data.data;
                HDR_W'(2): flags.raw[15:8] <= receive_data.data;
                HDR_W'(3): flags.raw[7:0]  <= receive_data.data;
                default: ;
            endcase
        end
    end

    // Open reassembly for this id first, else a free slot for a first fragment
    always_comb begin
        hit       = 1'b0;
        hit_index = '0;
        for (int i = SLOTS - 1; i >= 0; i--) begin
            if (!occupied_vec[i] && flags.fields.offset == '0) begin
                hit       = 1'b1;
                hit_index = IDX_W'(i);
            end
        end
        for (int i = SLOTS - 1; i >= 0; i--) begin
            if (occupied_vec[i] && !sealed_vec[i] && held_id_arr[i] == packet_id) begin
                hit       = 1'b1;
                hit_index = IDX_W'(i);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            hdr_count <= '0;
            sel_valid <= 1'b0;
            sel_index <= '0;
        end else begin
            if (receive_data_enable) begin
                if (receive_data.last) begin
                    hdr_count <= '0;
                end else if (hdr_count != PAYLOAD) begin
                    hdr_count <= hdr_count + 1'b1;
                end
            end
            if (checksum_done) begin
                sel_valid <= 1'b0;
            end else if (receive_data_enable && !receive_data.last &&
                         hdr_count == PAYLOAD - 1'b1) begin
                sel_valid <= hit;      // Short packets never get here
                sel_index <= hit_index;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Slot ports
    //////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < SLOTS; i++) begin : g_slot
        assign slots[i].select        = sel_valid && sel_index == IDX_W'(i);
        assign slots[i].write         = receive_data_enable && hdr_count == PAYLOAD;
        assign slots[i].data          = receive_data.data;
        assign slots[i].commit        = checksum_done && checksum_ok;
        assign slots[i].discard       = checksum_done && !checksum_ok;
        assign slots[i].last_fragment = !flags.fields.more_fragments;
        assign slots[i].packet_id     = packet_id;
        assign occupied_vec[i]        = slots[i].occupied;
        assign sealed_vec[i]          = slots[i].sealed;
        assign held_id_arr[i]         = slots[i].held_id;
    end

endmodule

// ==== hdl/virtual_port_rx.sv ====
// Virtual UDP port receive path from switch stream to module output
`timescale 1ns/1ps
`include "udp_rx_defines.svh"

module virtual_port_rx (
    input  logic       clock,
    input  logic       rst,
    input  logic [8:0] receive_data,              // Bit 8 marks last byte
    input  logic       receive_data_enable,
    input  logic       module_receive_ready,
    output logic [8:0] module_receive_data,
    output logic       module_receive_data_valid
);

    slot_write_if slot_write [`FRAGMENT_SLOTS] ();
    slot_read_if  slot_read  [`FRAGMENT_SLOTS] ();

    udp_rx_parser parser_inst (
        .clock               (clock),
        .rst                 (rst),
        .receive_data        (receive_data),
        .receive_data_enable (receive_data_enable),
        .slots               (slot_write)
    );

    for (genvar i = 0; i < `FRAGMENT_SLOTS; i++) begin : g_fragment_slot
        fragment_slot fragment_slot_inst (
            .clock (clock),
            .rst   (rst),
            .wr    (slot_write[i]),
            .rd    (slot_read[i])
        );
    end

    fragment_arbiter arbiter_inst (
        .clock                     (clock),
        .rst                       (rst),
        .module_receive_ready      (module_receive_ready),
        .slots                     (slot_read),
        .module_receive_data       (module_receive_data),
        .module_receive_data_valid (module_receive_data_valid)
    );

endmodule

// ==== reassembly/fragment_arbiter.sv ====
// Round-robin arbiter draining sealed slots onto the module output
`timescale 1ns/1ps
`include "udp_rx_defines.svh"

module fragment_arbiter (
    input  logic                     clock,
    input  logic                     rst,
    input  logic                     module_receive_ready,
    slot_read_if.arbiter             slots [`FRAGMENT_SLOTS],
    output udp_rx_pkg::stream_word_t module_receive_data,
    output logic                     module_receive_data_valid
);

    localparam int SLOTS = `FRAGMENT_SLOTS;
    localparam int IDX_W = (SLOTS > 1) ? $clog2(SLOTS) : 1;

    logic [SLOTS-1:0]         req_vec;
    logic [SLOTS-1:0]         valid_vec;
    udp_rx_pkg::stream_word_t data_arr [SLOTS];
    logic [IDX_W-1:0]         grant;      // Current or last granted slot
    logic [IDX_W-1:0]         next_grant;
    logic                     grant_open;
    logic                     found;

    for (genvar i = 0; i < SLOTS; i++) begin : g_slot
        assign req_vec[i]     = slots[i].req;
        assign valid_vec[i]   = slots[i].valid;
        assign data_arr[i]    = slots[i].data;
        assign slots[i].ack   = grant_open && grant == IDX_W'(i);
        assign slots[i].ready = module_receive_ready && grant_open && grant == IDX_W'(i);
    end

    // Search starts one past the last grant
    always_comb begin
        int cand;
        next_grant = grant;
        found      = 1'b0;
        for (int k = 1; k <= SLOTS; k++) begin
            cand = (int'(grant) + k) % SLOTS;
            if (!found && req_vec[cand]) begin
                found      = 1'b1;
                next_grant = IDX_W'(cand);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            grant_open <= 1'b0;
            grant      <= '0;
        end else if (!grant_open) begin
            if (found) begin
                grant_open <= 1'b1;
                grant      <= next_grant;
            end
        end else if (!req_vec[grant]) begin
            grant_open <= 1'b0;         // Slot finished, release ack
        end
    end

    assign module_receive_data       = data_arr[grant];
    assign module_receive_data_valid = grant_open && valid_vec[grant];

endmodule

// ==== reassembly/fragment_slot.sv ====
// One reassembly slot, appends fragments and drains the sealed datagram
`timescale 1ns/1ps
`include "udp_rx_defines.svh"

module fragment_slot (
    input  logic       clock,
    input  logic       rst,
    slot_write_if.slot wr,
    slot_read_if.slot  rd
);

    localparam int ADDR_W = $clog2(`SLOT_BYTES);
    localparam int PTR_W  = $clog2(`SLOT_BYTES + 1);
    localparam logic [PTR_W-1:0] CAPACITY = PTR_W'(`SLOT_BYTES);

    logic [7:0]             mem [`SLOT_BYTES];
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       committed;     // Bytes of accepted fragments
    logic [PTR_W-1:0]       rd_ptr;
    logic                   overflow;
    logic                   occupied;
    logic                   sealed;
    logic                   req;
    logic                   valid;
    udp_rx_pkg::packet_id_t held_id;
    logic                   wr_hit;
    logic                   rewind;
    logic                   load;

    assign wr_hit = wr.select && wr.write;
    assign rewind = wr.select && (wr.discard || (wr.commit && overflow));
    assign load   = (req && rd.ack && !valid) || (valid && rd.ready && !rd.data.last);

    assign wr.occupied = occupied;
    assign wr.sealed   = sealed;
    assign wr.held_id  = held_id;
    assign rd.req      = req;
    assign rd.valid    = valid;

    always_ff @(posedge clock) begin
        if (wr_hit && wr_ptr != CAPACITY) begin
            mem[wr_ptr[ADDR_W-1:0]] <= wr.data;
        end
        if (wr_hit && !occupied) begin
            held_id <= wr.packet_id;
        end
        if (load) begin
            rd.data.data <= mem[rd_ptr[ADDR_W-1:0]];
            rd.data.last <= (rd_ptr + 1'b1) == committed;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            wr_ptr    <= '0;
            committed <= '0;
            rd_ptr    <= '0;
            overflow  <= 1'b0;
            occupied  <= 1'b0;
            sealed    <= 1'b0;
            req       <= 1'b0;
            valid     <= 1'b0;
        end else begin
            if (wr_hit) begin
                occupied <= 1'b1;
                if (wr_ptr == CAPACITY) overflow <= 1'b1;
                else wr_ptr <= wr_ptr + 1'b1;
            end
            if (rewind) begin
                wr_ptr   <= committed;  // Drop the bad fragment only
                overflow <= 1'b0;
                if (committed == '0) occupied <= 1'b0;
            end else if (wr.select && wr.commit) begin
                committed <= wr_ptr;
                if (wr.last_fragment) begin
                    sealed <= 1'b1;
                    req    <= 1'b1;
                end
            end

            if (load) begin
                valid  <= 1'b1;
                rd_ptr <= rd_ptr + 1'b1;
            end else if (valid && rd.ready) begin
                valid <= 1'b0;          // Last byte taken
                req   <= 1'b0;
            end

            // Handshake closed, back to free
            if (sealed && !req && !rd.ack) begin
                occupied  <= 1'b0;
                sealed    <= 1'b0;
                wr_ptr    <= '0;
                committed <= '0;
                rd_ptr    <= '0;
            end
        end
    end

endmodule

// ==== verif/virtual_port_rx_asserts.sv ====
// Concurrent checks on the slot drain handshakes and the module output
`timescale 1ns/1ps
`include "udp_rx_defines.svh"

module virtual_port_rx_asserts (
    input logic                     clock,
    input logic                     rst,
    input logic                     module_receive_ready,
    input udp_rx_pkg::stream_word_t module_receive_data,
    input logic                     module_receive_data_valid,
    slot_read_if.arbiter            slots [`FRAGMENT_SLOTS]
);

    localparam int SLOTS = `FRAGMENT_SLOTS;

    logic [SLOTS-1:0] req_vec;
    logic [SLOTS-1:0] ack_vec;
    logic [SLOTS-1:0] last_taken;

    for (genvar i = 0; i < SLOTS; i++) begin : g_slot
        assign req_vec[i]    = slots[i].req;
        assign ack_vec[i]    = slots[i].ack;
        assign last_taken[i] = slots[i].valid && slots[i].ready && slots[i].data.last;

        req_after_last: assert property (@(posedge clock) disable iff (rst)
            $fell(req_vec[i]) |-> $past(last_taken[i]))
            else $error("slot %0d dropped req before its last byte was taken", i);
    end

    single_ack: assert property (@(posedge clock) disable iff (rst) $onehot0(ack_vec))
        else $error("ack high for more than one slot");

    // Back-pressure holds the output word
    output_hold: assert property (@(posedge clock) disable iff (rst)
        module_receive_data_valid && !module_receive_ready |=>
            module_receive_data_valid && $stable(module_receive_data))
        else $error("output changed while valid was high and ready low");

endmodule

bind fragment_arbiter virtual_port_rx_asserts asserts_inst (
    .clock                     (clock),
    .rst                       (rst),
    .module_receive_ready      (module_receive_ready),
    .module_receive_data       (module_receive_data),
    .module_receive_data_valid (module_receive_data_valid),
    .slots                     (slots)
);

// ==== verif/virtual_port_rx_tb.sv ====
// Directed testbench for the virtual UDP port receive path
`timescale 1ns/1ps
`include "udp_rx_defines.svh"

module virtual_port_rx_tb;

    typedef logic [7:0] byte_q_t [$];
    typedef logic [8:0] word_q_t [$];

    // Rough cycles per test in test order
    localparam int TEST_CYCLES  = 80 + 100 + 135 + 90 + 240;
    localparam int WAIT_LIMIT   = 600;
    localparam int QUIET_CYCLES = 12;

    logic       clock = 1'b0;
    logic       rst = 1'b1;
    logic [8:0] receive_data = '0;
    logic       receive_data_enable = 1'b0;
    logic       module_receive_ready = 1'b0;
    logic [8:0] module_receive_data;
    logic       module_receive_data_valid;
    logic       ready_random = 1'b0;
    integer     seed = 32'he764;
    word_q_t    rx_q;                          // Collected output words

    virtual_port_rx virtual_port_rx_inst (
        .clock                     (clock),
        .rst                       (rst),
        .receive_data              (receive_data),
        .receive_data_enable       (receive_data_enable),
        .module_receive_ready      (module_receive_ready),
        .module_receive_data       (module_receive_data),
        .module_receive_data_valid (module_receive_data_valid)
    );

    always #50 clock = ~clock;

    // Ready driver and output collector
    always @(posedge clock) begin
        module_receive_ready <= ready_random ? ($random(seed) % 2 != 0) : 1'b1;
        if (!rst && module_receive_data_valid && module_receive_ready) begin
            rx_q.push_back(module_receive_data);
        end
    end

    initial begin
        repeat (4 * TEST_CYCLES) @(posedge clock);
        fail_run("Watchdog expired before the tests finished");
    end

    //////////////////////////////////////////////////////////////////////
    // Packet model and stimulus
    //////////////////////////////////////////////////////////////////////

    // Checksum field chosen so the one's-complement sum is all ones
    function automatic void build_packet(
        input  logic [15:0] id,
        input  logic        mf,
        input  logic [12:0] offset,
        input  byte_q_t     payload,
        input  bit          corrupt,
        output byte_q_t     pkt
    );
        logic [15:0] flags_word;
        logic [15:0] word;
        logic [31:0] sum;
        logic [15:0] checksum;
        flags_word = {2'b00, mf, offset};
        sum = '0;
        pkt.delete();
        pkt.push_back(id[15:8]);
        pkt.push_back(id[7:0]);
        pkt.push_back(flags_word[15:8]);
        pkt.push_back(flags_word[7:0]);
        pkt.push_back(8'h00);
        pkt.push_back(8'h00);
        foreach (payload[i]) pkt.push_back(payload[i]);
        for (int i = 0; i < pkt.size(); i += 2) begin
            word = {pkt[i], (i + 1 < pkt.size()) ? pkt[i + 1] : 8'h00};  // Odd tail
            sum  = sum + {16'h0000, word};
        end
        sum = {16'h0000, sum[15:0]} + {16'h0000, sum[31:16]};
        sum = {16'h0000, sum[15:0]} + {16'h0000, sum[31:16]};
        checksum = ~sum[15:0];
        if (corrupt) checksum = checksum ^ 16'h0100;
        pkt[`HEADER_BYTES - 2] = checksum[15:8];
        pkt[`HEADER_BYTES - 1] = checksum[7:0];
    endfunction

    task automatic random_payload(input int len, output byte_q_t payload);
        payload.delete();
        for (int i = 0; i < len; i++) payload.push_back(8'($random(seed)));
    endtask

    function automatic void payload_words(input byte_q_t payload, output word_q_t words);
        words.delete();
        foreach (payload[i]) words.push_back({i == payload.size() - 1, payload[i]});
    endfunction

    task automatic send_packet(input byte_q_t pkt);
        for (int i = 0; i < pkt.size(); i++) begin
            @(posedge clock);
            receive_data        <= {i == pkt.size() - 1, pkt[i]};
            receive_data_enable <= 1'b1;
        end
        @(posedge clock);
        receive_data        <= '0;
        receive_data_enable <= 1'b0;
    endtask

    task automatic send_fragment(input logic [15:0] id, input logic mf,
                                 input logic [12:0] offset, input byte_q_t payload,
                                 input bit corrupt);
        byte_q_t pkt;
        build_packet(id, mf, offset, payload, corrupt, pkt);
        send_packet(pkt);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Checking
    //////////////////////////////////////////////////////////////////////

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic check_word(input string name, input int index,
                              input logic [8:0] expected, input logic [8:0] actual);
        assert (actual === expected) else begin
            fail_run($sformatf("ERROR %s: word %0d expected %03h actual %03h",
                               name, index, expected, actual));
        end
    endtask

    task automatic wait_words(input string name, input int count);
        int waited;
        waited = 0;
        while (rx_q.size() < count) begin
            if (waited == WAIT_LIMIT) begin
                fail_run($sformatf("%s timed out waiting for %0d output words, got %0d",
                                   name, count, rx_q.size()));
            end
            @(negedge clock);
            waited++;
        end
    endtask

    task automatic compare_words(input string name, input word_q_t expected);
        logic [8:0] actual;
        wait_words(name, expected.size());
        foreach (expected[i]) begin
            actual = rx_q.pop_front();
            check_word(name, i, expected[i], actual);
        end
    endtask

    task automatic check_quiet(input string name);
        repeat (QUIET_CYCLES) @(negedge clock);
        assert (rx_q.size() == 0) else begin
            fail_run($sformatf("ERROR %s: expected 0 extra words actual %0d",
                               name, rx_q.size()));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic single_datagram();
        byte_q_t payload;
        word_q_t expected;
        random_payload(24, payload);
        send_fragment(16'h1001, 1'b0, 13'd0, payload, 1'b0);
        payload_words(payload, expected);
        compare_words("single_datagram", expected);
        check_quiet("single_datagram");
    endtask

    task automatic bad_checksum();
        byte_q_t bad;
        byte_q_t good;
        word_q_t expected;
        random_payload(20, bad);
        random_payload(20, good);
        send_fragment(16'h2002, 1'b0, 13'd0, bad, 1'b1);
        send_fragment(16'h2003, 1'b0, 13'd0, good, 1'b0);
        payload_words(good, expected);
        compare_words("bad_checksum", expected);
        check_quiet("bad_checksum");
    endtask

    task automatic fragment_reassembly();
        byte_q_t part;
        byte_q_t whole;
        word_q_t expected;
        for (int f = 0; f < 3; f++) begin
            random_payload((f == 2) ? 10 : 16, part);
            send_fragment(16'h3003, f != 2, 13'(2 * f), part, 1'b0);
            foreach (part[i]) whole.push_back(part[i]);
        end
        payload_words(whole, expected);
        compare_words("fragment_reassembly", expected);
        check_quiet("fragment_reassembly");
    endtask

    task automatic orphan_and_short();
        byte_q_t orphan;
        byte_q_t short_pkt;
        byte_q_t good;
        word_q_t expected;
        random_payload(12, orphan);
        send_fragment(16'h4444, 1'b0, 13'd3, orphan, 1'b0);   // No open slot for this id
        random_payload(4, short_pkt);                         // Ends inside the header
        send_packet(short_pkt);
        random_payload(18, good);
        send_fragment(16'h4005, 1'b0, 13'd0, good, 1'b0);
        payload_words(good, expected);
        compare_words("orphan_and_short", expected);
        check_quiet("orphan_and_short");
    endtask

    task automatic interleaved_slots_backpressure();
        byte_q_t part;
        byte_q_t whole_a;
        byte_q_t whole_b;
        word_q_t first;
        word_q_t second;
        int      boundary;
        for (int f = 0; f < 3; f++) begin
            random_payload(10 + 2 * f, part);
            send_fragment(16'h5a5a, f != 2, 13'(2 * f), part, 1'b0);
            foreach (part[i]) whole_a.push_back(part[i]);
            random_payload(9 + f, part);
            send_fragment(16'h5b5b, f != 2, 13'(2 * f), part, 1'b0);
            foreach (part[i]) whole_b.push_back(part[i]);
        end
        ready_random <= 1'b1;
        wait_words("interleaved_slots_backpressure", whole_a.size() + whole_b.size());
        ready_random <= 1'b0;
        boundary = -1;
        for (int i = rx_q.size() - 1; i >= 0; i--) begin
            if (rx_q[i][8]) boundary = i;
        end
        // Lengths differ, so the first boundary tells the order
        if (boundary == whole_a.size() - 1) begin
            payload_words(whole_a, first);
            payload_words(whole_b, second);
        end else if (boundary == whole_b.size() - 1) begin
            payload_words(whole_b, first);
            payload_words(whole_a, second);
        end else begin
            fail_run($sformatf("interleaved_slots_backpressure: first datagram ends at %0d",
                               boundary));
        end
        compare_words("interleaved_slots_backpressure", first);
        compare_words("interleaved_slots_backpressure", second);
        check_quiet("interleaved_slots_backpressure");
    endtask

    initial begin
        repeat (2) @(posedge clock);
        rst <= 1'b0;
        @(posedge clock);
        single_datagram();
        bad_checksum();
        fragment_reassembly();
        orphan_and_short();
        interleaved_slots_backpressure();
        $display("TEST PASS");
        $finish;
    end

endmodule
